// File: design/axi_fifo_settings.svh
// global widths for the axi to fifo bridge
`ifndef AXI_FIFO_SETTINGS_SVH
`define AXI_FIFO_SETTINGS_SVH

// byte address width on the axi side and the fifo side
`define AXI_ADDR_W 32

// transaction id width on aw, ar, b and r
`define AXI_ID_W 4

// burst length field width, also the response counter width
`define AXI_LEN_W 8

// data bus is fixed at 64 bits, so size never exceeds 3
// only 8-byte beats may carry a len above zero
// WRAP bursts fall through to the INCR path
// bresp and rresp are always OKAY

`endif

// File: design/axi_fifo_pkg.sv
// shared channel structs and codes for the axi to fifo bridge
`include "axi_fifo_settings.svh"

package axi_fifo_pkg;

  typedef logic [63:0]            axi_data_t;
  typedef logic [7:0]             axi_strb_t;
  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_ID_W-1:0]   axi_id_t;
  typedef logic [`AXI_LEN_W-1:0]  axi_len_t;
  typedef logic [2:0]             axi_size_t;

  // anything other than FIXED is stepped like INCR
  typedef enum logic [1:0] {
    e_burst_fixed = 2'b00
    ,e_burst_incr = 2'b01
  } axi_burst_e;

  typedef enum logic [1:0] {
    e_resp_okay    = 2'b00
    ,e_resp_exokay = 2'b01
    ,e_resp_slverr = 2'b10
    ,e_resp_decerr = 2'b11
  } axi_resp_e;

  // aw and ar request
  typedef struct packed {
    axi_addr_t  addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_e burst;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    axi_data_t data;
    axi_id_t   id;
    logic      last;
    axi_resp_e resp;
  } axi_r_t;

  // single transfer handed from a burst pump to the sequencer
  typedef struct packed {
    axi_addr_t addr;
    axi_size_t size;
    axi_len_t  len;
    logic      first;
    logic      last;
  } pump_beat_t;

  typedef struct packed {
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t wmask;
    axi_size_t size;
    logic      w;
  } fifo_req_t;

  // w marks the acknowledge of a write
  typedef struct packed {
    axi_data_t data;
    logic      w;
  } fifo_rsp_t;

endpackage

// File: design/two_entry_fifo.sv
// two-slot circular FIFO for any packed payload, read side taken straight from storage
`timescale 1ns/1ps

module two_entry_fifo
  #(parameter type payload_t = logic)
  (input                  clk_i
   , input                reset_i

   , input  payload_t     data_i
   , input                v_i
   , output logic         ready_o

   , output payload_t     data_o
   , output logic         v_o
   , input                yumi_i
   );

  payload_t mem_r [2];
  logic     rd_ptr_r;
  logic     wr_ptr_r;
  logic     full_r;
  logic     empty_r;
  logic     enq;

  // a pop frees a slot in the same cycle, so a full fifo still takes a push then
  assign ready_o = ~full_r | yumi_i;
  assign enq = v_i & ready_o;

  assign v_o = ~empty_r;
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (enq) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (yumi_i) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // occupancy only changes when exactly one side moves
      if (enq & ~yumi_i) begin
        empty_r <= 1'b0;
        full_r  <= (rd_ptr_r == ~wr_ptr_r);
      end else if (yumi_i & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= (wr_ptr_r == ~rd_ptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

// File: design/axi_burst_pump.sv
// burst pump that turns one axi address request into a run of single-beat addresses
`timescale 1ns/1ps

module axi_burst_pump
  import axi_fifo_pkg::*;
  (input                  clk_i
   , input                reset_i

   // address channel from the axi manager
   , input  axi_ax_t      ax_i
   , input                ax_v_i
   , output logic         ax_ready_o

   // beats toward the sequencer
   , output pump_beat_t   beat_o
   , output logic         beat_v_o
   , input                send_i

   // id of the oldest unanswered burst
   , output axi_id_t      id_o
   , output logic         id_v_o
   , input                id_pop_i
   );

  logic       loaded_r;
  logic       first_r;
  axi_addr_t  addr_r;
  axi_size_t  size_r;
  axi_len_t   len_r;
  axi_len_t   count_r;
  axi_burst_e burst_r;

  logic       id_ready;
  logic       id_v_li;
  logic       load;
  logic       last_beat;
  axi_addr_t  addr_step;

  // both the pump and the id queue have to take the request together
  assign ax_ready_o = ~loaded_r & id_ready;
  assign id_v_li = ax_v_i & ~loaded_r;
  assign load = ax_v_i & ax_ready_o;

  // count_r holds the beats left after the current one
  assign last_beat = (count_r == '0);
  assign addr_step = axi_addr_t'(1) << size_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      loaded_r <= 1'b0;
    end else if (load) begin
      loaded_r <= 1'b1;
    end else if (send_i & last_beat) begin
      loaded_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_r  <= ax_i.addr;
      size_r  <= ax_i.size;
      len_r   <= ax_i.len;
      count_r <= ax_i.len;
      burst_r <= ax_i.burst;
      first_r <= 1'b1;
    end else if (send_i) begin
      count_r <= count_r - 1'b1;
      first_r <= 1'b0;
      // fixed bursts hit the same address every beat
      if (burst_r != e_burst_fixed) begin
        addr_r <= addr_r + addr_step;
      end
    end
  end

  assign beat_v_o = loaded_r;

  always_comb begin
    beat_o.addr  = addr_r;
    beat_o.size  = size_r;
    beat_o.len   = len_r;
    beat_o.first = first_r;
    beat_o.last  = last_beat;
  end

  // id is queued on load and held until the final response goes out
  two_entry_fifo
    #(.payload_t(axi_id_t))
    id_fifo
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.data_i(ax_i.id)
      ,.v_i(id_v_li)
      ,.ready_o(id_ready)
      ,.data_o(id_o)
      ,.v_o(id_v_o)
      ,.yumi_i(id_pop_i)
      );

endmodule

// File: design/axi_fifo_sequencer.sv
// read-priority request sequencer with transfer counter and b/r response routing
`timescale 1ns/1ps

module axi_fifo_sequencer
  import axi_fifo_pkg::*;
  (input                  clk_i
   , input                reset_i

   , input  pump_beat_t   wr_beat_i
   , input                wr_beat_v_i
   , output logic         wr_send_o
   , input  pump_beat_t   rd_beat_i
   , input                rd_beat_v_i
   , output logic         rd_send_o

   , input  axi_w_t       wdata_i
   , input                wdata_v_i

   , input  axi_id_t      wr_id_i
   , input                wr_id_v_i
   , output logic         wr_id_pop_o
   , input  axi_id_t      rd_id_i
   , input                rd_id_v_i
   , output logic         rd_id_pop_o

   , output fifo_req_t    req_o
   , output logic         req_v_o
   , input                req_ready_i

   , input  fifo_rsp_t    rsp_i
   , input                rsp_v_i
   , output logic         rsp_ready_o

   , output axi_b_t       b_o
   , output logic         b_v_o
   , input                b_ready_i
   , output axi_r_t       r_o
   , output logic         r_v_o
   , input                r_ready_i
   );

  typedef enum logic [1:0] {
    e_ready
    ,e_write
    ,e_read
    ,e_wait
  } state_e;

  state_e     state_r, state_n;
  logic       sel_rd;
  pump_beat_t beat;

  fifo_rsp_t  rsp_head;
  logic       rsp_head_v, rsp_yumi;
  axi_len_t   count_r;
  logic       last_transfer, b_send, r_send, last_rsp_send;

  // request valid and source select, reads win in the ready state
  always_comb begin
    req_v_o = 1'b0;
    sel_rd  = 1'b0;
    case (state_r)
      e_ready: begin
        sel_rd  = rd_beat_v_i;
        req_v_o = rd_beat_v_i | (wr_beat_v_i & wdata_v_i);
      end
      e_write: req_v_o = wr_beat_v_i & wdata_v_i;
      e_read: begin
        sel_rd  = 1'b1;
        req_v_o = rd_beat_v_i;
      end
      default: req_v_o = 1'b0;
    endcase
  end

  assign beat = sel_rd ? rd_beat_i : wr_beat_i;
  assign wr_send_o = req_v_o & ~sel_rd & req_ready_i;
  assign rd_send_o = req_v_o & sel_rd & req_ready_i;

  always_comb begin
    req_o.addr  = beat.addr;
    req_o.size  = beat.size;
    req_o.data  = wdata_i.data;
    req_o.wmask = wdata_i.strb;
    req_o.w     = ~sel_rd;
  end

  // single-beat bursts go straight to wait, longer ones stay on their source
  // a stalled write keeps the port so a later read cannot replace it
  always_comb begin
    state_n = state_r;
    case (state_r)
      e_ready: begin
        if (rd_send_o & ~rd_beat_i.last) state_n = e_read;
        else if (wr_send_o & ~wr_beat_i.last) state_n = e_write;
        else if (rd_send_o | wr_send_o) state_n = e_wait;
        else if (req_v_o & ~sel_rd) state_n = e_write;
      end
      e_write: if (wr_send_o & wr_beat_i.last) state_n = e_wait;
      e_read: if (rd_send_o & rd_beat_i.last) state_n = e_wait;
      default: if (last_rsp_send) state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_r <= e_ready;
    else state_r <= state_n;
  end

  two_entry_fifo
    #(.payload_t(fifo_rsp_t))
    rsp_fifo
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.data_i(rsp_i)
      ,.v_i(rsp_v_i)
      ,.ready_o(rsp_ready_o)
      ,.data_o(rsp_head)
      ,.v_o(rsp_head_v)
      ,.yumi_i(rsp_yumi)
      );

  // responses still owed after the head, loaded from len on the first beat
  always_ff @(posedge clk_i) begin
    if (reset_i) count_r <= '0;
    else if ((wr_send_o & wr_beat_i.first) | (rd_send_o & rd_beat_i.first))
      count_r <= beat.len;
    else if (rsp_yumi & ~last_transfer) count_r <= count_r - 1'b1;
  end

  assign last_transfer = (count_r == '0);
  assign b_send = b_v_o & b_ready_i;
  assign r_send = r_v_o & r_ready_i;
  assign last_rsp_send = b_send | (r_send & last_transfer);

  // write acks before the last one are dropped without a b
  assign rsp_yumi = r_send | b_send | (rsp_head_v & rsp_head.w & ~last_transfer);

  assign b_v_o = rsp_head_v & rsp_head.w & last_transfer & wr_id_v_i;
  assign b_o = '{id: wr_id_i, resp: e_resp_okay};
  assign wr_id_pop_o = b_send;

  assign r_v_o = rsp_head_v & ~rsp_head.w & rd_id_v_i;
  assign r_o = '{data: rsp_head.data, id: rd_id_i, last: last_transfer, resp: e_resp_okay};
  assign rd_id_pop_o = r_send & last_transfer;

endmodule

// File: design/axi_to_fifo_bridge.sv
// axi4 subordinate to in-order fifo request/response bridge
`timescale 1ns/1ps

module axi_to_fifo_bridge
  import axi_fifo_pkg::*;
  (input                  clk_i
   , input                reset_i

   // axi subordinate side
   , input  axi_ax_t      aw_i
   , input                aw_v_i
   , output logic         aw_ready_o
   , input  axi_w_t       w_i
   , input                w_v_i
   , output logic         w_ready_o
   , output axi_b_t       b_o
   , output logic         b_v_o
   , input                b_ready_i
   , input  axi_ax_t      ar_i
   , input                ar_v_i
   , output logic         ar_ready_o
   , output axi_r_t       r_o
   , output logic         r_v_o
   , input                r_ready_i

   // fifo side
   , output fifo_req_t    req_o
   , output logic         req_v_o
   , input                req_ready_i
   , input  fifo_rsp_t    rsp_i
   , input                rsp_v_i
   , output logic         rsp_ready_o
   );

  pump_beat_t aw_beat, ar_beat;
  logic       aw_beat_v, ar_beat_v;
  logic       aw_send, ar_send;
  axi_id_t    aw_id, ar_id;
  logic       aw_id_v, ar_id_v;
  logic       aw_id_pop, ar_id_pop;
  axi_w_t     w_head;
  logic       w_head_v;

  axi_burst_pump aw_pump
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.ax_i(aw_i), .ax_v_i(aw_v_i), .ax_ready_o(aw_ready_o)
     ,.beat_o(aw_beat), .beat_v_o(aw_beat_v), .send_i(aw_send)
     ,.id_o(aw_id), .id_v_o(aw_id_v), .id_pop_i(aw_id_pop)
     );

  axi_burst_pump ar_pump
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.ax_i(ar_i), .ax_v_i(ar_v_i), .ax_ready_o(ar_ready_o)
     ,.beat_o(ar_beat), .beat_v_o(ar_beat_v), .send_i(ar_send)
     ,.id_o(ar_id), .id_v_o(ar_id_v), .id_pop_i(ar_id_pop)
     );

  // write beats are popped by every write send
  two_entry_fifo #(.payload_t(axi_w_t)) w_fifo
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.data_i(w_i), .v_i(w_v_i), .ready_o(w_ready_o)
     ,.data_o(w_head), .v_o(w_head_v), .yumi_i(aw_send)
     );

  axi_fifo_sequencer sequencer
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.wr_beat_i(aw_beat), .wr_beat_v_i(aw_beat_v), .wr_send_o(aw_send)
     ,.rd_beat_i(ar_beat), .rd_beat_v_i(ar_beat_v), .rd_send_o(ar_send)
     ,.wdata_i(w_head), .wdata_v_i(w_head_v)
     ,.wr_id_i(aw_id), .wr_id_v_i(aw_id_v), .wr_id_pop_o(aw_id_pop)
     ,.rd_id_i(ar_id), .rd_id_v_i(ar_id_v), .rd_id_pop_o(ar_id_pop)
     ,.req_o(req_o), .req_v_o(req_v_o), .req_ready_i(req_ready_i)
     ,.rsp_i(rsp_i), .rsp_v_i(rsp_v_i), .rsp_ready_o(rsp_ready_o)
     ,.b_o(b_o), .b_v_o(b_v_o), .b_ready_i(b_ready_i)
     ,.r_o(r_o), .r_v_o(r_v_o), .r_ready_i(r_ready_i)
     );

endmodule

// File: verification/fifo_mem_model.sv
// in-order memory responder for the fifo port, with random request stalls
`timescale 1ns/1ps

module fifo_mem_model
  import axi_fifo_pkg::*;
  #(parameter logic [31:0] seed_p = 32'h0)
  (input                  clk_i
   , input                reset_i

   , input  fifo_req_t    req_i
   , input                req_v_i
   , output logic         req_ready_o

   , output fifo_rsp_t    rsp_o
   , output logic         rsp_v_o
   , input                rsp_ready_i
   );

  axi_data_t  mem [256];
  integer     seed = seed_p;
  logic       stall_r;
  logic       rsp_v_r;
  fifo_rsp_t  rsp_r;
  logic [7:0] idx;
  logic       accept;

  assign idx = req_i.addr[10:3];

  // one response slot, a new request only when it drains
  assign req_ready_o = ~stall_r & (~rsp_v_r | rsp_ready_i);
  assign accept = req_v_i & req_ready_o;
  assign rsp_v_o = rsp_v_r;
  assign rsp_o = rsp_r;

  always @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_r <= 1'b0;
      stall_r <= 1'b0;
      // each word holds its aligned address and the inverse above it
      for (int i = 0; i < 256; i++) begin
        mem[i] <= {~(32'(i) << 3), 32'(i) << 3};
      end
    end else begin
      // about one cycle in four refuses a request
      stall_r <= (($random(seed) & 3) == 0);
      if (accept) begin
        rsp_v_r    <= 1'b1;
        rsp_r.w    <= req_i.w;
        rsp_r.data <= req_i.w ? '0 : mem[idx];
        for (int b = 0; b < 8; b++) begin
          if (req_i.w && req_i.wmask[b]) begin
            mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end else if (rsp_ready_i) begin
        rsp_v_r <= 1'b0;
      end
    end
  end

endmodule

// File: verification/axi_fifo_tb.sv
// testbench for the axi to fifo bridge with a shadow memory and response scoreboards
`timescale 1ns/1ps

module axi_fifo_tb
  import axi_fifo_pkg::*;
  ();

  localparam logic [31:0] seed_init = 32'hcbec3156;
  localparam int rand_iters = 8;
  // sizes 8, incr read 4, writes and read backs 13, random up to 8 each, concurrent 8
  localparam int total_beats = 8 + 4 + 13 + rand_iters * 8 + 8;
  localparam int timeout_ns = 4 * total_beats * 40;

  logic      clk_i;
  logic      reset_i;
  axi_ax_t   aw_i;
  logic      aw_v_i;
  logic      aw_ready_o;
  axi_w_t    w_i;
  logic      w_v_i;
  logic      w_ready_o;
  axi_b_t    b_o;
  logic      b_v_o;
  logic      b_ready_i;
  axi_ax_t   ar_i;
  logic      ar_v_i;
  logic      ar_ready_o;
  axi_r_t    r_o;
  logic      r_v_o;
  logic      r_ready_i;
  fifo_req_t req_o;
  logic      req_v_o;
  logic      req_ready_i;
  fifo_rsp_t rsp_i;
  logic      rsp_v_i;
  logic      rsp_ready_o;

  integer    seed;
  integer    ready_seed;
  string     test_name;
  logic      stim_started;
  axi_data_t shadow [256];
  fifo_req_t wr_req_q [$];
  fifo_req_t rd_req_q [$];
  axi_r_t    r_exp_q [$];
  axi_b_t    b_exp_q [$];
  int        b_beats_q [$];
  int        wr_req_cnt;
  int        b_done_cnt;
  int        r_done_cnt;

  always #2 clk_i = ~clk_i;

  axi_to_fifo_bridge uut
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.aw_i(aw_i), .aw_v_i(aw_v_i), .aw_ready_o(aw_ready_o)
     ,.w_i(w_i), .w_v_i(w_v_i), .w_ready_o(w_ready_o)
     ,.b_o(b_o), .b_v_o(b_v_o), .b_ready_i(b_ready_i)
     ,.ar_i(ar_i), .ar_v_i(ar_v_i), .ar_ready_o(ar_ready_o)
     ,.r_o(r_o), .r_v_o(r_v_o), .r_ready_i(r_ready_i)
     ,.req_o(req_o), .req_v_o(req_v_o), .req_ready_i(req_ready_i)
     ,.rsp_i(rsp_i), .rsp_v_i(rsp_v_i), .rsp_ready_o(rsp_ready_o)
     );

  fifo_mem_model #(.seed_p(seed_init)) mem_model
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.req_i(req_o), .req_v_i(req_v_o), .req_ready_o(req_ready_i)
     ,.rsp_o(rsp_i), .rsp_v_o(rsp_v_i), .rsp_ready_i(rsp_ready_o)
     );

  task automatic fail_run(string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_value(string field, logic [63:0] expected, logic [63:0] actual);
    assert (expected === actual) else
      fail_run($sformatf("[ERROR] test %s, %s: expected %h, actual %h",
                         test_name, field, expected, actual));
  endtask

  // fixed repeats the base, incr steps by the beat size
  function automatic axi_addr_t next_addr(axi_addr_t base, int beat, axi_size_t size,
                                          axi_burst_e burst);
    if (burst == e_burst_fixed) return base;
    return base + (axi_addr_t'(beat) << size);
  endfunction

  task automatic aw_handshake(axi_ax_t ax);
    logic hs = 1'b0;
    aw_i = ax;
    aw_v_i = 1'b1;
    while (!hs) begin
      @(negedge clk_i);
      hs = aw_ready_o;
      @(posedge clk_i);
    end
    #1 aw_v_i = 1'b0;
  endtask

  task automatic w_handshake(axi_w_t beat);
    logic hs = 1'b0;
    w_i = beat;
    w_v_i = 1'b1;
    while (!hs) begin
      @(negedge clk_i);
      hs = w_ready_o;
      @(posedge clk_i);
    end
    #1 w_v_i = 1'b0;
  endtask

  task automatic ar_handshake(axi_ax_t ax);
    logic hs = 1'b0;
    ar_i = ax;
    ar_v_i = 1'b1;
    while (!hs) begin
      @(negedge clk_i);
      hs = ar_ready_o;
      @(posedge clk_i);
    end
    #1 ar_v_i = 1'b0;
  endtask

  task automatic write_burst(axi_addr_t addr, axi_id_t id, axi_len_t len, axi_size_t size,
                             axi_burst_e burst, axi_strb_t strb);
    axi_data_t beat_data [4];
    axi_addr_t beat_addr;
    axi_ax_t   ax;
    axi_w_t    wbeat;
    axi_b_t    exp_b;
    fifo_req_t exp_req;
    int        target;
    for (int i = 0; i <= len; i++) begin
      beat_addr = next_addr(addr, i, size, burst);
      beat_data[i] = {$random(seed), $random(seed)};
      exp_req.addr = beat_addr;
      exp_req.data = beat_data[i];
      exp_req.wmask = strb;
      exp_req.size = size;
      exp_req.w = 1'b1;
      wr_req_q.push_back(exp_req);
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) shadow[beat_addr[10:3]][8*b +: 8] = beat_data[i][8*b +: 8];
      end
    end
    exp_b.id = id;
    exp_b.resp = e_resp_okay;
    b_exp_q.push_back(exp_b);
    b_beats_q.push_back(len + 1);
    ax = '{addr: addr, id: id, len: len, size: size, burst: burst};
    target = b_done_cnt + 1;
    fork
      aw_handshake(ax);
      for (int i = 0; i <= len; i++) begin
        wbeat.data = beat_data[i];
        wbeat.strb = strb;
        w_handshake(wbeat);
      end
    join
    while (b_done_cnt < target) @(posedge clk_i);
    #1;
  endtask

  task automatic read_burst(axi_addr_t addr, axi_id_t id, axi_len_t len, axi_size_t size,
                            axi_burst_e burst);
    axi_addr_t beat_addr;
    axi_r_t    exp_r;
    axi_ax_t   ax;
    fifo_req_t exp_req;
    int        target;
    for (int i = 0; i <= len; i++) begin
      beat_addr = next_addr(addr, i, size, burst);
      exp_req = '0;
      exp_req.addr = beat_addr;
      exp_req.size = size;
      rd_req_q.push_back(exp_req);
      exp_r.data = shadow[beat_addr[10:3]];
      exp_r.id = id;
      exp_r.last = (i == len);
      exp_r.resp = e_resp_okay;
      r_exp_q.push_back(exp_r);
    end
    ax = '{addr: addr, id: id, len: len, size: size, burst: burst};
    target = r_done_cnt + len + 1;
    ar_handshake(ax);
    while (r_done_cnt < target) @(posedge clk_i);
    #1;
  endtask

  // random back-pressure on b and r once stimulus runs
  always @(posedge clk_i) begin
    if (stim_started) begin
      #1;
      b_ready_i = (($random(ready_seed) & 3) != 0);
      r_ready_i = (($random(ready_seed) & 3) != 0);
    end
  end

  // transfers complete on the next rising edge, so sample in between
  always @(negedge clk_i) begin
    if (!reset_i && req_v_o && req_ready_i) begin
      if (req_o.w) begin
        if (wr_req_q.size() == 0) fail_run("write request with no write burst outstanding");
        check_value("write request address", wr_req_q[0].addr, req_o.addr);
        check_value("write request size", wr_req_q[0].size, req_o.size);
        check_value("write request data", wr_req_q[0].data, req_o.data);
        check_value("write request mask", wr_req_q[0].wmask, req_o.wmask);
        void'(wr_req_q.pop_front());
        wr_req_cnt++;
      end else begin
        if (rd_req_q.size() == 0) fail_run("read request with no read burst outstanding");
        check_value("read request address", rd_req_q[0].addr, req_o.addr);
        check_value("read request size", rd_req_q[0].size, req_o.size);
        void'(rd_req_q.pop_front());
      end
    end
    if (!reset_i && b_v_o && b_ready_i) begin
      if (b_exp_q.size() == 0) fail_run("write response with no write burst outstanding");
      check_value("bid", b_exp_q[0].id, b_o.id);
      check_value("bresp", b_exp_q[0].resp, b_o.resp);
      check_value("write requests before b", b_beats_q[0], wr_req_cnt);
      void'(b_exp_q.pop_front());
      void'(b_beats_q.pop_front());
      wr_req_cnt = 0;
      b_done_cnt++;
    end
    if (!reset_i && r_v_o && r_ready_i) begin
      if (r_exp_q.size() == 0) fail_run("read response with no read beat outstanding");
      check_value("rdata", r_exp_q[0].data, r_o.data);
      check_value("rid", r_exp_q[0].id, r_o.id);
      check_value("rlast", r_exp_q[0].last, r_o.last);
      check_value("rresp", r_exp_q[0].resp, r_o.resp);
      void'(r_exp_q.pop_front());
      r_done_cnt++;
    end
  end

  idle_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    !stim_started |-> (!req_v_o && !b_v_o && !r_v_o && aw_ready_o && ar_ready_o && w_ready_o
                       && rsp_ready_o))
    else fail_run("bridge outputs not idle after reset");

  b_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (b_v_o && !b_ready_i) |=> (b_v_o && $stable(b_o)))
    else fail_run("bvalid dropped or b payload changed while bready was low");

  r_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (r_v_o && !r_ready_i) |=> (r_v_o && $stable(r_o)))
    else fail_run("rvalid dropped or r payload changed while rready was low");

  initial begin
    #(timeout_ns);
    fail_run("timeout: transactions did not complete in time");
  end

  initial begin
    axi_addr_t  addr;
    axi_strb_t  lanes;
    axi_len_t   len;
    axi_burst_e burst;
    clk_i = 1'b0;
    reset_i = 1'b1;
    stim_started = 1'b0;
    aw_i = '0;
    aw_v_i = 1'b0;
    w_i = '0;
    w_v_i = 1'b0;
    ar_i = '0;
    ar_v_i = 1'b0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    seed = seed_init;
    ready_seed = seed_init;
    wr_req_cnt = 0;
    b_done_cnt = 0;
    r_done_cnt = 0;
    test_name = "reset";
    for (int i = 0; i < 256; i++) begin
      shadow[i] = {~(32'(i) << 3), 32'(i) << 3};
    end
    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 stim_started = 1'b1;

    test_name = "single_write_sizes";
    for (int s = 0; s < 4; s++) begin
      // offset equal to the beat size, so byte, half and word land off lane zero
      addr = 32'h40 + 32'(s) * 8 + ((32'd1 << s) & 32'd7);
      lanes = 8'(((16'd1 << (1 << s)) - 16'd1) << addr[2:0]);
      write_burst(addr, axi_id_t'(s), 0, axi_size_t'(s), e_burst_incr, lanes & 8'h5a);
      read_burst(addr, axi_id_t'(s + 8), 0, axi_size_t'(s), e_burst_incr);
    end

    test_name = "incr_read_len3";
    read_burst(32'h100, 4'h5, 3, 3, e_burst_incr);

    test_name = "incr_write_len3";
    write_burst(32'h200, 4'h9, 3, 3, e_burst_incr, 8'hff);
    read_burst(32'h200, 4'h2, 3, 3, e_burst_incr);

    test_name = "fixed_write_len3";
    write_burst(32'h300, 4'h7, 3, 3, e_burst_fixed, 8'h3c);
    read_burst(32'h300, 4'h1, 0, 3, e_burst_incr);

    test_name = "random_bursts";
    for (int n = 0; n < rand_iters; n++) begin
      len = axi_len_t'($random(seed) & 3);
      burst = ($random(seed) & 1) ? e_burst_fixed : e_burst_incr;
      addr = axi_addr_t'(($random(seed) & 32'h7f) << 3);
      lanes = axi_strb_t'($random(seed)) | 8'h01;
      write_burst(addr, axi_id_t'(n), len, 3, burst, lanes);
      read_burst(addr, axi_id_t'(n + 1), len, 3, burst);
    end

    // disjoint addresses keep the expected data independent of the order
    test_name = "concurrent_read_write";
    repeat (2) begin
      fork
        write_burst(32'h600, 4'h3, 1, 3, e_burst_incr, 8'hf0);
        read_burst(32'h700, 4'hc, 1, 3, e_burst_incr);
      join
    end

    if (r_exp_q.size() != 0 || b_exp_q.size() != 0 || wr_req_q.size() != 0
        || rd_req_q.size() != 0) begin
      fail_run("requests or responses still outstanding at the end of the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+design
design/axi_fifo_pkg.sv
design/two_entry_fifo.sv
design/axi_burst_pump.sv
design/axi_fifo_sequencer.sv
design/axi_to_fifo_bridge.sv
verification/fifo_mem_model.sv
verification/axi_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the bridge testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module axi_fifo_tb \
  || { echo "build failed"; exit 1; }

./obj_dir/Vaxi_fifo_tb | tee /dev/stderr | grep -q -F "*** TEST PASSED ***" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
